// ==== hw/io_defines.svh ====
`ifndef IO_DEFINES_SVH
`define IO_DEFINES_SVH

`define IO_ADDR_WIDTH       16
`define IO_DATA_WIDTH       32
`define IO_SIZE_WIDTH       3
`define IRQ_LINE_COUNT      16

`define IO_HDD0_BASE        16'h01F0
`define IO_HDD0_ALT         16'h03F6
`define IO_HDD1_BASE        16'h0170
`define IO_HDD1_ALT         16'h0376
`define IO_FDD_BASE         16'h03F0
`define IO_JOY_PORT         16'h0201
`define IO_DMA_MASTER_BASE  16'h00C0
`define IO_DMA_PAGE_BASE    16'h0080
`define IO_DMA_SLAVE_BASE   16'h0000
`define IO_PIC_MASTER_BASE  16'h0020
`define IO_PIC_SLAVE_BASE   16'h00A0
`define IO_PIT_BASE         16'h0040
`define IO_PIT_SPEAKER      16'h0061
`define IO_PS2_IO_BASE      16'h0060
`define IO_PS2_CTL_BASE     16'h0090
`define IO_RTC_BASE         16'h0070
`define IO_FM_BASE          16'h0388
`define IO_SB_BASE          16'h0220
`define IO_UART_BASE        16'h03F8
`define IO_MPU_BASE         16'h0330
`define IO_VGA_B_BASE       16'h03B0
`define IO_VGA_C_BASE       16'h03C0
`define IO_VGA_D_BASE       16'h03D0
`define IO_SYSCTL_PORT      16'h8888

// low address bits ignored by a range
`define IO_ALIGN_2          1
`define IO_ALIGN_4          2
`define IO_ALIGN_8          3
`define IO_ALIGN_16         4
`define IO_ALIGN_32         5

`define SYSCTL_KEY          8'hA1
`define SYSCTL_RESET_VALUE  8'hA2
`define SYSCTL_WORD_SIZE    3'd2

`endif

// ==== hw/io_pkg.sv ====
`default_nettype none

`include "io_defines.svh"

package io_pkg;

	typedef logic [`IO_ADDR_WIDTH-1:0]  io_addr_t;
	typedef logic [`IO_DATA_WIDTH-1:0]  io_data_t;
	typedef logic [7:0]                 io_byte_t;
	typedef logic [`IO_SIZE_WIDTH-1:0]  io_size_t;
	typedef logic [`IRQ_LINE_COUNT-1:0] irq_lines_t;

	typedef struct packed {
		io_addr_t address;
		logic     read;
		logic     write;
		io_size_t datasize;
		io_data_t writedata;
	} io_bus_t;

	// one bit per legacy port range
	typedef struct packed {
		logic hdd0;
		logic hdd1;
		logic joy;
		logic floppy;
		logic dma_master;
		logic dma_page;
		logic dma_slave;
		logic pic_master;
		logic pic_slave;
		logic pit;
		logic ps2_io;
		logic ps2_ctl;
		logic rtc;
		logic fm;
		logic sb;
		logic uart;
		logic mpu;
		logic vga_b;
		logic vga_c;
		logic vga_d;
		logic sysctl;
	} io_select_t;

	typedef struct packed {
		io_data_t hdd0;
		io_data_t hdd1;
		io_byte_t floppy;
		io_byte_t dma;
		io_byte_t pic;
		io_byte_t pit;
		io_byte_t ps2;
		io_byte_t rtc;
		io_byte_t sound;
		io_byte_t uart;
		io_byte_t vga;
		io_byte_t joystick;
	} io_dev_rdata_t;

	typedef struct packed {
		logic pit;
		logic kbd;
		logic vga;
		logic uart;
		logic sound;
		logic floppy;
		logic rtc;
		logic mpu;
		logic mouse;
		logic hdd0;
		logic hdd1;
	} io_dev_irq_t;

	typedef enum logic [0:0] {
		BOOT_HOLD,
		RUNNING
	} sysctl_state_t;

endpackage

`default_nettype wire

// ==== hw/io_port_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "io_defines.svh"

module io_port_decode import io_pkg::*; (
	input  wire logic clk_sys,
	input  io_addr_t  address,
	output io_select_t io_sel
);

	// compare with the low alignment bits dropped
	function automatic logic range_hit(
		input io_addr_t    addr,
		input io_addr_t    base,
		input int unsigned align
	);
		range_hit = (addr >> align) == (base >> align);
	endfunction

	always_ff @(posedge clk_sys) begin
		io_sel.hdd0       <= range_hit(address, `IO_HDD0_BASE, `IO_ALIGN_8)
		                     || (address == `IO_HDD0_ALT); // alt status / dev ctl
		io_sel.hdd1       <= range_hit(address, `IO_HDD1_BASE, `IO_ALIGN_8)
		                     || (address == `IO_HDD1_ALT);
		io_sel.joy        <= (address == `IO_JOY_PORT);
		io_sel.floppy     <= range_hit(address, `IO_FDD_BASE, `IO_ALIGN_8);
		io_sel.dma_master <= range_hit(address, `IO_DMA_MASTER_BASE, `IO_ALIGN_32);
		io_sel.dma_page   <= range_hit(address, `IO_DMA_PAGE_BASE, `IO_ALIGN_16);
		io_sel.dma_slave  <= range_hit(address, `IO_DMA_SLAVE_BASE, `IO_ALIGN_16);
		io_sel.pic_master <= range_hit(address, `IO_PIC_MASTER_BASE, `IO_ALIGN_2);
		io_sel.pic_slave  <= range_hit(address, `IO_PIC_SLAVE_BASE, `IO_ALIGN_2);
		io_sel.pit        <= range_hit(address, `IO_PIT_BASE, `IO_ALIGN_4)
		                     || (address == `IO_PIT_SPEAKER); // speaker gate port
		io_sel.ps2_io     <= range_hit(address, `IO_PS2_IO_BASE, `IO_ALIGN_8);
		io_sel.ps2_ctl    <= range_hit(address, `IO_PS2_CTL_BASE, `IO_ALIGN_16);
		io_sel.rtc        <= range_hit(address, `IO_RTC_BASE, `IO_ALIGN_2);
		io_sel.fm         <= range_hit(address, `IO_FM_BASE, `IO_ALIGN_4);
		io_sel.sb         <= range_hit(address, `IO_SB_BASE, `IO_ALIGN_16);
		io_sel.uart       <= range_hit(address, `IO_UART_BASE, `IO_ALIGN_8);
		io_sel.mpu        <= range_hit(address, `IO_MPU_BASE, `IO_ALIGN_2);
		io_sel.vga_b      <= range_hit(address, `IO_VGA_B_BASE, `IO_ALIGN_16);
		io_sel.vga_c      <= range_hit(address, `IO_VGA_C_BASE, `IO_ALIGN_16);
		io_sel.vga_d      <= range_hit(address, `IO_VGA_D_BASE, `IO_ALIGN_16);
		io_sel.sysctl     <= (address == `IO_SYSCTL_PORT);
	end

endmodule

`default_nettype wire

// ==== hw/sysctl_port.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "io_defines.svh"

module sysctl_port import io_pkg::*; (
	input  wire logic  clk_sys,
	input  wire logic  reset_cpu,
	input  io_bus_t    bus,
	input  io_select_t io_sel,
	output io_byte_t   syscfg
);

	sysctl_state_t state;
	logic          disk_access;
	logic          boot_release;
	logic          key_write;

	assign disk_access  = io_sel.hdd0 || io_sel.hdd1 || io_sel.floppy;
	assign boot_release = (state == BOOT_HOLD) && disk_access; // bios touched a drive

	// keyed 16-bit write to the control port
	assign key_write = bus.write
	                   && io_sel.sysctl
	                   && (bus.datasize == `SYSCTL_WORD_SIZE)
	                   && (bus.writedata[15:8] == `SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			state  <= BOOT_HOLD;
			syscfg <= `SYSCTL_RESET_VALUE;
		end else if (boot_release) begin
			state  <= RUNNING;
			syscfg <= '0;
		end else if (key_write) begin
			state  <= RUNNING; // from either state
			syscfg <= bus.writedata[7:0];
		end
	end

endmodule

`default_nettype wire

// ==== hw/io_read_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_read_mux import io_pkg::*; (
	input  io_addr_t      address,
	input  io_select_t    io_sel,
	input  io_dev_rdata_t dev_rdata,
	output io_data_t      bus_readdata,
	output logic          bus_io32
);

	io_byte_t rdata8;

	// first selected 8-bit device wins
	always_comb begin
		if (io_sel.floppy) begin
			rdata8 = dev_rdata.floppy;
		end else if (io_sel.dma_master || io_sel.dma_slave || io_sel.dma_page) begin
			rdata8 = dev_rdata.dma;
		end else if (io_sel.pic_master || io_sel.pic_slave) begin
			rdata8 = dev_rdata.pic;
		end else if (io_sel.pit) begin
			rdata8 = dev_rdata.pit;
		end else if (io_sel.ps2_io || io_sel.ps2_ctl) begin
			rdata8 = dev_rdata.ps2;
		end else if (io_sel.rtc) begin
			rdata8 = dev_rdata.rtc;
		end else if (io_sel.sb || io_sel.fm) begin
			rdata8 = dev_rdata.sound;
		end else if (io_sel.uart || io_sel.mpu) begin
			rdata8 = dev_rdata.uart;
		end else if (io_sel.vga_b || io_sel.vga_c || io_sel.vga_d) begin
			rdata8 = dev_rdata.vga;
		end else if (io_sel.joy) begin
			rdata8 = dev_rdata.joystick;
		end else begin
			rdata8 = 8'hFF; // open bus
		end
	end

	always_comb begin
		if (io_sel.hdd0) begin
			bus_readdata = dev_rdata.hdd0;
		end else if (io_sel.hdd1) begin
			bus_readdata = dev_rdata.hdd1;
		end else begin
			bus_readdata = io_data_t'(rdata8);
		end
	end

	// disk data ports sit below 200h unlike the 3x6h aliases
	assign bus_io32 = ((io_sel.hdd0 || io_sel.hdd1) && !address[9]) || io_sel.sysctl;

endmodule

`default_nettype wire

// ==== hw/io_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

module io_subsystem import io_pkg::*; (
	input  wire logic    clk_sys,
	input  wire logic    reset_cpu,
	input  io_bus_t      bus,
	input  io_dev_rdata_t dev_rdata,
	input  io_dev_irq_t  dev_irq,
	output io_select_t   io_sel,
	output io_data_t     bus_readdata,
	output logic         bus_io32,
	output io_byte_t     syscfg,
	output irq_lines_t   interrupt
);

	io_port_decode i_io_port_decode (
		.clk_sys (clk_sys),
		.address (bus.address),
		.io_sel  (io_sel)
	);

	sysctl_port i_sysctl_port (
		.clk_sys   (clk_sys),
		.reset_cpu (reset_cpu),
		.bus       (bus),
		.io_sel    (io_sel),
		.syscfg    (syscfg)
	);

	io_read_mux i_io_read_mux (
		.address      (bus.address),
		.io_sel       (io_sel),
		.dev_rdata    (dev_rdata),
		.bus_readdata (bus_readdata),
		.bus_io32     (bus_io32)
	);

	// irq2 from vga is cascaded onto line 9 with the mpu
	assign interrupt = {
		dev_irq.hdd1,              // 15
		dev_irq.hdd0,              // 14
		1'b0,
		dev_irq.mouse,             // 12
		1'b0,
		1'b0,
		dev_irq.mpu | dev_irq.vga, // 9
		dev_irq.rtc,               // 8
		1'b0,
		dev_irq.floppy,            // 6
		dev_irq.sound,             // 5
		dev_irq.uart,              // 4
		1'b0,
		1'b0,                      // 2 is the slave pic input
		dev_irq.kbd,               // 1
		dev_irq.pit                // 0
	};

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset_por
);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys; // 100 ns period
	end

	// held over the first four rising edges
	initial begin
		reset_por = 1'b1;
		repeat (4) @(posedge clk_sys);
		#10 reset_por = 1'b0;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_io_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "io_defines.svh"

module tb_io_subsystem import io_pkg::*; ();

	localparam int N_RANGE = 24; // 21 ranges in select order plus three aliases
	localparam io_addr_t RANGE_BASE [N_RANGE] = '{
		`IO_HDD0_BASE, `IO_HDD1_BASE, `IO_JOY_PORT, `IO_FDD_BASE,
		`IO_DMA_MASTER_BASE, `IO_DMA_PAGE_BASE, `IO_DMA_SLAVE_BASE,
		`IO_PIC_MASTER_BASE, `IO_PIC_SLAVE_BASE, `IO_PIT_BASE,
		`IO_PS2_IO_BASE, `IO_PS2_CTL_BASE, `IO_RTC_BASE, `IO_FM_BASE, `IO_SB_BASE,
		`IO_UART_BASE, `IO_MPU_BASE, `IO_VGA_B_BASE, `IO_VGA_C_BASE, `IO_VGA_D_BASE,
		`IO_SYSCTL_PORT, `IO_HDD0_ALT, `IO_HDD1_ALT, `IO_PIT_SPEAKER
	};
	localparam int RANGE_ALIGN [N_RANGE] = '{
		3, 3, 0, 3, 5, 4, 4, 1, 1, 2, 3, 4, 1, 2, 4, 3, 1, 4, 4, 4, 0, 0, 0, 0
	};
	localparam int N_RAND_DECODE = 128;
	localparam int N_RAND_READ = 64;
	localparam int N_IRQ = 64;
	localparam int TEST_CYCLES = 8 + 4 * N_RANGE + N_RAND_DECODE
	                             + 2 * (N_RANGE + N_RAND_READ) + 24 + 30 + N_IRQ + 4;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

	logic          clk_sys;
	logic          reset_por;
	logic          reset_tb;
	logic          reset_cpu;
	io_bus_t       bus;
	io_dev_rdata_t dev_rdata;
	io_dev_irq_t   dev_irq;
	io_select_t    io_sel;
	io_data_t      bus_readdata;
	logic          bus_io32;
	io_byte_t      syscfg;
	irq_lines_t    interrupt;

	string         test_name = "reset";
	logic [31:0]   lfsr_state = 32'h6413_b534;
	logic [8:0]    exp_cfg = 9'h000; // boot hold flag and syscfg
	io_select_t    exp_sel = '0;
	int            cycle_count = 0;

	assign reset_cpu = reset_por | reset_tb;

	tb_clock_gen i_tb_clock_gen (
		.clk_sys   (clk_sys),
		.reset_por (reset_por)
	);

	io_subsystem i_io_subsystem (
		.clk_sys      (clk_sys),
		.reset_cpu    (reset_cpu),
		.bus          (bus),
		.dev_rdata    (dev_rdata),
		.dev_irq      (dev_irq),
		.io_sel       (io_sel),
		.bus_readdata (bus_readdata),
		.bus_io32     (bus_io32),
		.syscfg       (syscfg),
		.interrupt    (interrupt)
	);

	function automatic logic lfsr_bit();
		lfsr_bit = lfsr_state[31];
		lfsr_state = {lfsr_state[30:0],
		              lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		int j;
		v = '0;
		for (j = 0; j < n; j++) begin
			v = {v[30:0], lfsr_bit()};
		end
		take_bits = v;
	endfunction

	function automatic io_addr_t random_address();
		if (lfsr_bit()) begin
			random_address = io_addr_t'(take_bits(16));
		end else begin
			random_address = io_addr_t'(take_bits(10)); // legacy space below 400h
		end
	endfunction

	function automatic io_dev_rdata_t random_rdata();
		io_dev_rdata_t v;
		int j;
		for (j = 0; j < $bits(io_dev_rdata_t); j++) begin
			v[j] = lfsr_bit();
		end
		random_rdata = v;
	endfunction

	function automatic logic range_match(input io_addr_t addr, input io_addr_t base,
	                                     input int align);
		range_match = (addr & ~io_addr_t'((1 << align) - 1)) == base;
	endfunction

	function automatic io_select_t ref_select(input io_addr_t addr);
		logic [20:0] s;
		int i;
		for (i = 0; i < 21; i++) begin
			s[20 - i] = range_match(addr, RANGE_BASE[i], RANGE_ALIGN[i]);
		end
		ref_select = io_select_t'(s);
		ref_select.hdd0 = ref_select.hdd0 | (addr == 16'h03F6);
		ref_select.hdd1 = ref_select.hdd1 | (addr == 16'h0376);
		ref_select.pit = ref_select.pit | (addr == 16'h0061);
	endfunction

	function automatic io_data_t ref_readdata(input io_select_t sel, input io_dev_rdata_t d);
		io_byte_t r8;
		r8 = sel.floppy ? d.floppy :
		     (sel.dma_master | sel.dma_slave | sel.dma_page) ? d.dma :
		     (sel.pic_master | sel.pic_slave) ? d.pic :
		     sel.pit ? d.pit :
		     (sel.ps2_io | sel.ps2_ctl) ? d.ps2 :
		     sel.rtc ? d.rtc :
		     (sel.sb | sel.fm) ? d.sound :
		     (sel.uart | sel.mpu) ? d.uart :
		     (sel.vga_b | sel.vga_c | sel.vga_d) ? d.vga :
		     sel.joy ? d.joystick : 8'hFF;
		ref_readdata = sel.hdd0 ? d.hdd0 : sel.hdd1 ? d.hdd1 : {24'h0, r8};
	endfunction

	function automatic logic ref_io32(input io_select_t sel, input io_addr_t addr);
		ref_io32 = sel.sysctl || ((sel.hdd0 || sel.hdd1) && addr[9] == 1'b0);
	endfunction

	function automatic irq_lines_t ref_irq(input io_dev_irq_t q);
		irq_lines_t v;
		v = '0;
		v[0] = q.pit;
		v[1] = q.kbd;
		v[4] = q.uart;
		v[5] = q.sound;
		v[6] = q.floppy;
		v[8] = q.rtc;
		v[9] = q.mpu | q.vga; // irq2 cascade
		v[12] = q.mouse;
		v[14] = q.hdd0;
		v[15] = q.hdd1;
		ref_irq = v;
	endfunction

	function automatic logic [8:0] ref_syscfg(input logic [8:0] cur, input logic rst,
	                                          input io_select_t sel, input io_bus_t b);
		if (rst) begin
			ref_syscfg = {1'b1, 8'hA2};
		end else if (cur[8] && (sel.hdd0 || sel.hdd1 || sel.floppy)) begin
			ref_syscfg = 9'h000;
		end else if (b.write && sel.sysctl && b.datasize == 3'd2
		             && b.writedata[15:8] == 8'hA1) begin
			ref_syscfg = {1'b0, b.writedata[7:0]};
		end else begin
			ref_syscfg = cur;
		end
	endfunction

	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string signal, input logic [31:0] expected,
	                     input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("ERROR %s: %s expected %h actual %h", test_name, signal, expected, actual);
			fail_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic drive_address(input io_addr_t addr);
		bus.address = addr;
		next_cycle();
	endtask

	// strobe follows the address by one cycle
	task automatic bus_access(input io_addr_t addr, input logic wr, input io_size_t size,
	                          input io_data_t data);
		drive_address(addr);
		bus.read = !wr;
		bus.write = wr;
		bus.datasize = size;
		bus.writedata = data;
		next_cycle();
		bus.read = 1'b0;
		bus.write = 1'b0;
		bus.datasize = '0;
	endtask

	task automatic pulse_reset();
		reset_tb = 1'b1;
		repeat (2) next_cycle();
		reset_tb = 1'b0;
	endtask

	always begin : compare_outputs
		@(posedge clk_sys);
		exp_cfg = ref_syscfg(exp_cfg, reset_cpu, exp_sel, bus);
		exp_sel = ref_select(bus.address);
		@(negedge clk_sys);
		check("io_sel", 32'(exp_sel), 32'(io_sel));
		check("bus_readdata", ref_readdata(exp_sel, dev_rdata), bus_readdata);
		check("bus_io32", 32'(ref_io32(exp_sel, bus.address)), 32'(bus_io32));
		check("syscfg", 32'(exp_cfg[7:0]), 32'(syscfg));
		check("interrupt", 32'(ref_irq(dev_irq)), 32'(interrupt));
	end

	always @(posedge clk_sys) begin : watchdog
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	initial begin : stimulus
		int i;
		int k;
		bus = '0;
		dev_rdata = '0;
		dev_irq = '0;
		reset_tb = 1'b0;
		wait (reset_por == 1'b0);
		next_cycle();

		test_name = "reset_value";
		check("syscfg", 32'h0000_00A2, 32'(syscfg));

		test_name = "decode";
		for (i = 0; i < N_RANGE; i++) begin
			k = 1 << RANGE_ALIGN[i]; // range size
			drive_address(RANGE_BASE[i]);
			drive_address(RANGE_BASE[i] + io_addr_t'(k) - 16'd1);
			drive_address(RANGE_BASE[i] - 16'd1);
			drive_address(RANGE_BASE[i] + io_addr_t'(k));
		end
		for (i = 0; i < N_RAND_DECODE; i++) begin
			drive_address(random_address());
		end

		test_name = "read_path";
		for (i = 0; i < N_RANGE + N_RAND_READ; i++) begin
			bus.address = (i < N_RANGE) ? RANGE_BASE[i] : random_address();
			repeat (2) begin
				dev_rdata = random_rdata();
				next_cycle();
			end
		end

		test_name = "boot_release";
		drive_address(16'h0070);
		pulse_reset();
		check("syscfg", 32'h0000_00A2, 32'(syscfg));
		bus_access(16'h0060, 1'b0, 3'd0, '0);
		check("syscfg", 32'h0000_00A2, 32'(syscfg));
		bus_access(16'h01F0, 1'b0, 3'd2, '0); // first disk access
		check("syscfg", 32'h0000_0000, 32'(syscfg));
		bus_access(16'h8888, 1'b1, 3'd2, 32'h0000_A15A);
		bus_access(16'h03F0, 1'b0, 3'd0, '0);
		check("syscfg", 32'h0000_005A, 32'(syscfg));

		test_name = "control_write";
		bus_access(16'h8888, 1'b1, 3'd2, 32'h1234_A13C);
		check("syscfg", 32'h0000_003C, 32'(syscfg));
		bus_access(16'h8888, 1'b1, 3'd2, 32'h0000_A2FF); // wrong key
		bus_access(16'h8888, 1'b1, 3'd1, 32'h0000_A1FF); // byte access
		bus_access(16'h8889, 1'b1, 3'd2, 32'h0000_A1FF);
		bus_access(16'h8888, 1'b0, 3'd2, 32'h0000_A1FF);
		check("syscfg", 32'h0000_003C, 32'(syscfg));
		pulse_reset();
		check("syscfg", 32'h0000_00A2, 32'(syscfg));
		bus_access(16'h8888, 1'b1, 3'd2, 32'h0000_A177);
		check("syscfg", 32'h0000_0077, 32'(syscfg));

		test_name = "interrupts";
		for (i = 0; i < N_IRQ; i++) begin
			for (k = 0; k < $bits(io_dev_irq_t); k++) begin
				dev_irq[k] = lfsr_bit();
			end
			next_cycle();
		end

		repeat (2) next_cycle();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/io_pkg.sv
hw/io_port_decode.sv
hw/sysctl_port.sv
hw/io_read_mux.sv
hw/io_subsystem.sv
testbench/tb_clock_gen.sv
testbench/tb_io_subsystem.sv

// ==== Bender.yml ====
package:
  name: io_subsystem

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/io_pkg.sv
      - hw/io_port_decode.sv
      - hw/sysctl_port.sv
      - hw/io_read_mux.sv
      - hw/io_subsystem.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_io_subsystem.sv
